// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= ex_stage_tb
FILELIST ?= ex_stage.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== ex_stage.f ====
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_multiplier.sv
hw/ex_stage_reg.sv
hw/ex_stage.sv
verification/ex_stage_asserts.sv
verification/ex_stage_tb.sv

// ==== hw/ex_alu.sv ====
`timescale 1ns/1ns
module ex_alu
	import ex_pkg::*;
(
	input alu_op_e op,
	input word_t src_a,
	input word_t src_b,
	output word_t result
);

	logic [5:0] shamt; // 64-bit shifts
	logic [4:0] shamt_w; // word shifts
	logic [31:0] word_res;

	// sign-extend a 32-bit result to the full data width
	function automatic word_t sext_word(input logic [31:0] w);
		return {{(xlen-32){w[31]}}, w};
	endfunction

	assign shamt = src_b[5:0];
	assign shamt_w = src_b[4:0];

	always_comb begin
		word_res = '0;
		result = '0;
		case (op)
			op_add: result = src_a + src_b;
			op_addw: begin
				word_res = src_a[31:0] + src_b[31:0];
				result = sext_word(word_res);
			end
			op_sll: result = src_a << shamt;
			op_sllw: begin
				word_res = src_a[31:0] << shamt_w;
				result = sext_word(word_res);
			end
			op_sra: result = $signed(src_a) >>> shamt;
			op_sraw: begin
				word_res = $signed(src_a[31:0]) >>> shamt_w;
				result = sext_word(word_res);
			end
			op_srl: result = src_a >> shamt;
			op_srlw: begin
				word_res = src_a[31:0] >> shamt_w;
				result = sext_word(word_res);
			end
			op_and: result = src_a & src_b;
			op_or: result = src_a | src_b;
			op_xor: result = src_a ^ src_b;
			op_slt: result = word_t'($signed(src_a) < $signed(src_b));
			op_sltu: result = word_t'(src_a < src_b);
			op_seq: result = word_t'(src_a == src_b);
			op_sne: result = word_t'(src_a != src_b); // also the bne test
			op_sge: result = word_t'($signed(src_a) >= $signed(src_b));
			op_sgeu: result = word_t'(src_a >= src_b);
			op_sub: result = src_a - src_b;
			op_subw: begin
				word_res = src_a[31:0] - src_b[31:0];
				result = sext_word(word_res);
			end
			default: result = '0; // multiplies and unknown codes
		endcase
	end

endmodule

// ==== hw/ex_multiplier.sv ====
`timescale 1ns/1ns
module ex_multiplier
	import ex_pkg::*;
#(
	parameter int width = xlen
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic accept,
	input alu_op_e op,
	input word_t src_a,
	input word_t src_b,
	output logic done,
	output word_t product
);

	localparam int cnt_w = $clog2(width);

	mul_state_e state;
	logic [cnt_w-1:0] count;
	logic last_step;
	logic is_signed;
	logic [width-1:0] opnd_a;
	logic [width-1:0] opnd_b;
	logic [width-1:0] mag_a;
	logic [width-1:0] mag_b;
	logic [width-1:0] mcand;
	logic [2*width-1:0] acc; // high half sums while the low half shifts out the multiplier
	logic [width:0] partial;
	logic [2*width-1:0] next_acc;
	logic neg;

	assign is_signed = (op == op_mulh) || (op == op_mulw);

	always_comb begin
		if (op == op_mulw) begin
			opnd_a = {{(width-32){src_a[31]}}, src_a[31:0]};
			opnd_b = {{(width-32){src_b[31]}}, src_b[31:0]};
		end else begin
			opnd_a = src_a[width-1:0];
			opnd_b = src_b[width-1:0];
		end
	end

	assign mag_a = (is_signed && opnd_a[width-1]) ? -opnd_a : opnd_a;
	assign mag_b = (is_signed && opnd_b[width-1]) ? -opnd_b : opnd_b;

	assign partial = acc[2*width-1:width] + (acc[0] ? mcand : '0);
	assign next_acc = {partial, acc[width-1:1]};
	assign last_step = count == cnt_w'(width - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mul_idle;
			count <= '0;
		end else begin
			case (state)
				mul_idle: if (start) begin
					state <= mul_busy;
					count <= '0;
				end
				mul_busy: begin
					count <= count + 1'b1;
					if (last_step)
						state <= mul_done;
				end
				mul_done: if (accept)
					state <= mul_idle;
				default: state <= mul_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == mul_idle && start) begin
			mcand <= mag_b;
			acc <= {{width{1'b0}}, mag_a};
			neg <= is_signed && (opnd_a[width-1] ^ opnd_b[width-1]);
		end else if (state == mul_busy) begin
			if (last_step)
				acc <= neg ? -next_acc : next_acc; // fix the sign on the final step
			else
				acc <= next_acc;
		end
	end

	assign done = state == mul_done;

	always_comb begin
		case (op)
			op_mulh, op_mulhu: product = word_t'(acc[2*width-1:width]);
			op_mulw: product = {{(xlen-32){acc[31]}}, acc[31:0]};
			default: product = word_t'(acc[width-1:0]);
		endcase
	end

endmodule

// ==== hw/ex_pkg.sv ====
package ex_pkg;

	localparam int xlen = 64;

	typedef logic [xlen-1:0] word_t;
	typedef logic [xlen-1:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [11:0] bimm_t; // imm[12:1] of a branch
	typedef logic [1:0] mem_size_t;

	localparam mem_size_t size_byte = 2'd0;
	localparam mem_size_t size_half = 2'd1;
	localparam mem_size_t size_word = 2'd2;
	localparam mem_size_t size_dword = 2'd3;

	typedef enum logic [4:0] {
		op_add = 5'd0,
		op_addw = 5'd1,
		op_sll = 5'd2,
		op_sllw = 5'd3,
		op_sra = 5'd4,
		op_sraw = 5'd5,
		op_srl = 5'd6,
		op_srlw = 5'd7,
		op_and = 5'd8,
		op_or = 5'd9,
		op_xor = 5'd10,
		op_slt = 5'd11,
		op_sltu = 5'd12,
		op_seq = 5'd13,
		op_sne = 5'd14,
		op_sge = 5'd15,
		op_sgeu = 5'd16,
		op_sub = 5'd17,
		op_subw = 5'd18,
		op_mul = 5'd19, // unsigned low half
		op_mulh = 5'd20, // signed x signed high half
		op_mulhu = 5'd21,
		op_mulw = 5'd22
	} alu_op_e;

	typedef enum logic [1:0] {
		mul_idle = 2'd0,
		mul_busy = 2'd1,
		mul_done = 2'd2
	} mul_state_e;

endpackage

// ==== hw/ex_stage.sv ====
`timescale 1ns/1ns
module ex_stage
	import ex_pkg::*;
#(
	parameter int width = xlen
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic out_ready,
	input logic aw_ready,
	input logic ar_ready,
	input logic branch,
	input logic mem_write_in,
	input logic wb_from_mem_in,
	input logic reg_write_in,
	input alu_op_e op,
	input addr_t pc_in,
	input inst_t inst_in,
	input word_t rt_data,
	input reg_idx_t rdest_in,
	input word_t src_a,
	input word_t src_b,
	input bimm_t bimm,
	output logic in_ready,
	output logic out_valid,
	output logic flush,
	output logic branch_taken,
	output addr_t branch_target,
	output addr_t pc,
	output inst_t inst,
	output logic mem_write,
	output logic wb_from_mem,
	output logic reg_write,
	output word_t store_data,
	output reg_idx_t rdest,
	output word_t alu_result,
	output logic aw_valid,
	output logic ar_valid,
	output addr_t aw_addr,
	output addr_t ar_addr,
	output mem_size_t aw_size,
	output word_t w_data
);

	logic is_mul;
	logic is_store;
	logic is_load;
	logic ready_sel;
	logic transfer;
	logic mul_start;
	logic mul_accept;
	logic mul_done;
	word_t alu_out;
	word_t mul_product;
	word_t result;

	assign is_mul = op inside {op_mul, op_mulh, op_mulhu, op_mulw};
	assign is_store = mem_write_in;
	assign is_load = wb_from_mem_in && !mem_write_in; // store takes priority

	ex_alu u_alu (
		.op(op),
		.src_a(src_a),
		.src_b(src_b),
		.result(alu_out)
	);

	// ignored by the multiplier unless it is idle
	assign mul_start = in_valid && is_mul;
	assign mul_accept = transfer && is_mul;

	ex_multiplier #(
		.width(width)
	) u_mul (
		.clk(clk),
		.reset(reset),
		.start(mul_start),
		.accept(mul_accept),
		.op(op),
		.src_a(src_a),
		.src_b(src_b),
		.done(mul_done),
		.product(mul_product)
	);

	assign result = is_mul ? mul_product : alu_out;

	always_comb begin
		if (is_store)
			ready_sel = aw_ready;
		else if (is_load)
			ready_sel = ar_ready;
		else
			ready_sel = out_ready;
	end

	assign in_ready = ready_sel && (!is_mul || mul_done); // stall until product ready
	assign transfer = in_valid && in_ready;

	assign aw_valid = is_store && in_valid;
	assign ar_valid = is_load && in_valid;
	assign aw_addr = result;
	assign ar_addr = result;
	assign w_data = rt_data;

	always_comb begin
		case (inst_in[14:12])
			3'b000: aw_size = size_byte;
			3'b001: aw_size = size_half;
			3'b010: aw_size = size_word;
			default: aw_size = size_dword; // sd and anything else
		endcase
	end

	assign branch_target = pc_in + {{(xlen-13){bimm[11]}}, bimm, 1'b0};
	assign branch_taken = branch && (result != '0);
	assign flush = branch_taken && transfer;

	ex_stage_reg u_reg (
		.clk(clk),
		.reset(reset),
		.load(transfer),
		.out_ready(out_ready),
		.pc_in(pc_in),
		.inst_in(inst_in),
		.mem_write_in(mem_write_in),
		.wb_from_mem_in(wb_from_mem_in),
		.reg_write_in(reg_write_in),
		.store_data_in(rt_data),
		.rdest_in(rdest_in),
		.result_in(result),
		.out_valid(out_valid),
		.pc(pc),
		.inst(inst),
		.mem_write(mem_write),
		.wb_from_mem(wb_from_mem),
		.reg_write(reg_write),
		.store_data(store_data),
		.rdest(rdest),
		.alu_result(alu_result)
	);

endmodule

// ==== hw/ex_stage_reg.sv ====
`timescale 1ns/1ns
module ex_stage_reg
	import ex_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic load,
	input logic out_ready,
	input addr_t pc_in,
	input inst_t inst_in,
	input logic mem_write_in,
	input logic wb_from_mem_in,
	input logic reg_write_in,
	input word_t store_data_in,
	input reg_idx_t rdest_in,
	input word_t result_in,
	output logic out_valid,
	output addr_t pc,
	output inst_t inst,
	output logic mem_write,
	output logic wb_from_mem,
	output logic reg_write,
	output word_t store_data,
	output reg_idx_t rdest,
	output word_t alu_result
);

	// load wins over a downstream take
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_write <= 1'b0;
			wb_from_mem <= 1'b0;
			reg_write <= 1'b0;
		end else if (load) begin
			mem_write <= mem_write_in;
			wb_from_mem <= wb_from_mem_in;
			reg_write <= reg_write_in;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			pc <= pc_in;
			inst <= inst_in;
			store_data <= store_data_in;
			rdest <= rdest_in;
			alu_result <= result_in;
		end
	end

endmodule

// ==== verification/ex_stage_asserts.sv ====
`timescale 1ns/1ns
module ex_stage_asserts
	import ex_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic in_ready,
	input logic flush,
	input logic aw_valid,
	input logic ar_valid,
	input logic out_valid,
	input logic out_ready,
	input addr_t pc,
	input inst_t inst,
	input logic mem_write,
	input logic wb_from_mem,
	input logic reg_write,
	input word_t store_data,
	input reg_idx_t rdest,
	input word_t alu_result,
	input logic done,
	input mul_state_e state
);

	localparam int rec_w = $bits(addr_t) + $bits(inst_t) + 3 + 2 * $bits(word_t)
		+ $bits(reg_idx_t);

	logic [rec_w-1:0] record; // whole EX/MEM record
	assign record = {pc, inst, mem_write, wb_from_mem, reg_write, store_data, rdest, alu_result};

	flush_on_transfer: assert property (@(posedge clk) disable iff (reset)
		flush |=> out_valid && alu_result != '0)
		else $error("flush raised without a taken branch entering EX/MEM");

	bus_request_recorded: assert property (@(posedge clk) disable iff (reset)
		(aw_valid || ar_valid) && in_ready |=> out_valid && (mem_write != wb_from_mem))
		else $error("accepted bus request not recorded as one store or one load");

	record_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(record))
		else $error("EX/MEM record changed while downstream stalled");

	done_until_accept: assert property (@(posedge clk) disable iff (reset)
		done && !(in_valid && in_ready) |=> done)
		else $error("multiplier dropped done before its product was accepted");

	idle_after_accept: assert property (@(posedge clk) disable iff (reset)
		done && in_valid && in_ready |=> state == mul_idle)
		else $error("multiplier not idle after its product was accepted");

endmodule

// ==== verification/ex_stage_tb.sv ====
`timescale 1ns/1ns
module ex_stage_tb
	import ex_pkg::*;
();

	localparam int n_ops = 300;
	localparam int timeout_limit = n_ops * (xlen + 4);

	typedef struct packed {
		addr_t pc;
		inst_t inst;
		logic mem_write;
		logic wb_from_mem;
		logic reg_write;
		word_t store_data;
		reg_idx_t rdest;
		word_t result;
	} record_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic in_valid = 1'b0, out_ready = 1'b0, aw_ready = 1'b0, ar_ready = 1'b0;
	logic branch = 1'b0, mem_write_in = 1'b0, wb_from_mem_in = 1'b0, reg_write_in = 1'b0;
	alu_op_e op = op_add;
	addr_t pc_in = '0;
	inst_t inst_in = '0;
	word_t rt_data = '0, src_a = '0, src_b = '0;
	reg_idx_t rdest_in = '0;
	bimm_t bimm = '0;
	logic in_ready, out_valid, flush, branch_taken, aw_valid, ar_valid;
	logic mem_write, wb_from_mem, reg_write;
	addr_t branch_target, pc, aw_addr, ar_addr;
	inst_t inst;
	word_t store_data, alu_result, w_data;
	reg_idx_t rdest;
	mem_size_t aw_size;

	integer seed = 32'he5359952;
	int cycles = 0;
	int accepted = 0;
	int mul_wait = 0; // sampled cycles the current instruction has waited
	logic pending = 1'b0;
	record_t exp_q[$]; // accepted but not yet taken downstream

	ex_stage #(.width(xlen)) UUT (.*);

	bind ex_stage ex_stage_asserts u_asserts (
		.clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
		.flush(flush), .aw_valid(aw_valid), .ar_valid(ar_valid),
		.out_valid(out_valid), .out_ready(out_ready), .pc(pc), .inst(inst),
		.mem_write(mem_write), .wb_from_mem(wb_from_mem), .reg_write(reg_write),
		.store_data(store_data), .rdest(rdest), .alu_result(alu_result),
		.done(mul_done), .state(u_mul.state)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_limit)
			stop_with_failure($sformatf("timeout, run still busy after %0d cycles", cycles));
	end

	function automatic word_t sign_extend_word(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	function automatic word_t random_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	function automatic word_t expected_result(input alu_op_e o, input word_t a, input word_t b);
		logic [127:0] uprod;
		logic signed [127:0] sprod;
		logic signed [63:0] wprod;
		word_t r;
		uprod = {64'd0, a} * {64'd0, b};
		sprod = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
		wprod = $signed({{32{a[31]}}, a[31:0]}) * $signed({{32{b[31]}}, b[31:0]});
		case (o)
			op_add: r = a + b;
			op_addw: r = sign_extend_word(a[31:0] + b[31:0]);
			op_sll: r = a << b[5:0];
			op_sllw: r = sign_extend_word(a[31:0] << b[4:0]);
			op_sra: r = $signed(a) >>> b[5:0];
			op_sraw: r = sign_extend_word($signed(a[31:0]) >>> b[4:0]);
			op_srl: r = a >> b[5:0];
			op_srlw: r = sign_extend_word(a[31:0] >> b[4:0]);
			op_and: r = a & b;
			op_or: r = a | b;
			op_xor: r = a ^ b;
			op_slt: r = {63'd0, $signed(a) < $signed(b)};
			op_sltu: r = {63'd0, a < b};
			op_seq: r = {63'd0, a == b};
			op_sne: r = {63'd0, a != b};
			op_sge: r = {63'd0, $signed(a) >= $signed(b)};
			op_sgeu: r = {63'd0, a >= b};
			op_sub: r = a - b;
			op_subw: r = sign_extend_word(a[31:0] - b[31:0]);
			op_mul: r = uprod[63:0];
			op_mulh: r = sprod[127:64];
			op_mulhu: r = uprod[127:64];
			op_mulw: r = sign_extend_word(wprod[31:0]);
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			stop_with_failure($sformatf("%s mismatch", name));
		end
	endtask

	// a new instruction only after the previous one transferred
	task automatic drive_inputs();
		logic [31:0] r;
		logic [31:0] k;
		r = $random(seed);
		out_ready = r[1:0] != 2'd0;
		aw_ready = out_ready && r[3:2] != 2'd0; // bus takes a request only when EX/MEM can
		ar_ready = out_ready && r[5:4] != 2'd0;
		if (!pending) begin
			if (accepted < n_ops && r[7:6] != 2'd0) begin
				k = $random(seed);
				k = k % 32'd23;
				op = alu_op_e'(k[4:0]);
				src_a = random_word();
				src_b = (r[10:8] == 3'd0) ? src_a : random_word();
				pc_in = random_word();
				rt_data = random_word();
				k = $random(seed);
				branch = k[1:0] == 2'd3; // plain, store, load or branch
				mem_write_in = k[1:0] == 2'd1;
				wb_from_mem_in = k[1:0] == 2'd2;
				reg_write_in = k[1:0] == 2'd2 || (k[1:0] == 2'd0 && k[2]);
				rdest_in = k[7:3];
				bimm = k[19:8];
				inst_in = $random(seed);
				in_valid = 1'b1;
				pending = 1'b1;
				mul_wait = 0;
			end else begin
				in_valid = 1'b0;
			end
		end
	endtask

	task automatic score_cycle();
		word_t exp_res;
		logic sel;
		logic exp_ready;
		logic xfer;
		if (out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				stop_with_failure("output record offered with no instruction accepted");
			end else begin
				check_value("pc", exp_q[0].pc, pc);
				check_value("inst", 64'(exp_q[0].inst), 64'(inst));
				check_value("mem_write", 64'(exp_q[0].mem_write), 64'(mem_write));
				check_value("wb_from_mem", 64'(exp_q[0].wb_from_mem), 64'(wb_from_mem));
				check_value("reg_write", 64'(exp_q[0].reg_write), 64'(reg_write));
				check_value("store_data", exp_q[0].store_data, store_data);
				check_value("rdest", 64'(exp_q[0].rdest), 64'(rdest));
				check_value("alu_result", exp_q[0].result, alu_result);
				void'(exp_q.pop_front());
			end
		end
		exp_res = expected_result(op, src_a, src_b);
		xfer = in_valid && in_ready;
		check_value("aw_valid", 64'(in_valid && mem_write_in), 64'(aw_valid));
		check_value("ar_valid", 64'(in_valid && wb_from_mem_in), 64'(ar_valid));
		if (in_valid) begin
			sel = mem_write_in ? aw_ready : (wb_from_mem_in ? ar_ready : out_ready);
			exp_ready = sel && !(op >= op_mul && mul_wait <= xlen); // width+1 cycles busy
			check_value("in_ready", 64'(exp_ready), 64'(in_ready));
			check_value("aw_size", 64'((inst_in[14:12] > 3'd2) ? 3'd3 : inst_in[14:12]),
				64'(aw_size));
			check_value("branch_target", pc_in + (addr_t'($signed(bimm)) << 1), branch_target);
			check_value("w_data", rt_data, w_data);
			if (xfer) begin
				check_value("branch_taken", 64'(branch && exp_res != '0), 64'(branch_taken));
				if (mem_write_in)
					check_value("aw_addr", exp_res, aw_addr);
				if (wb_from_mem_in)
					check_value("ar_addr", exp_res, ar_addr);
				exp_q.push_back(record_t'({pc_in, inst_in, mem_write_in, wb_from_mem_in,
					reg_write_in, rt_data, rdest_in, exp_res}));
				accepted++;
				pending = 1'b0;
			end else begin
				mul_wait++;
			end
		end
		check_value("flush", 64'(xfer && branch && exp_res != '0), 64'(flush));
	endtask

	initial begin
		repeat (4) @(negedge clk);
		reset = 1'b0;
		#1;
		check_value("reset out_valid", 64'd0, 64'(out_valid));
		check_value("reset reg_write", 64'd0, 64'(reg_write));
		check_value("reset mem_write", 64'd0, 64'(mem_write));
		check_value("reset flush", 64'd0, 64'(flush));
		while (accepted < n_ops || exp_q.size() != 0) begin
			@(negedge clk);
			drive_inputs();
			#1; // settled in the low phase before the rising edge
			score_cycle();
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule
